//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
TOP        := tb_mips
FILELIST   := tb.f
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output word_t   i_inst_addr,
    input  word_t   i_inst_rdata,
    input  fwd_t    m_fwd,
    input  fwd_t    w_fwd,
    input  hazard_t e_hazard,
    input  hazard_t m_hazard,
    output de_reg_t de_out
);

    word_t     pc;
    word_t     npc;
    word_t     fd_pc;
    word_t     fd_instr;
    opcode_t   op;
    funct_t    fn;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     rf_rs;
    word_t     rf_rt;
    word_t     rs_val;
    word_t     rt_val;
    word_t     pc_plus4_d;
    word_t     br_target;
    word_t     jal_target;
    ctrl_t     ctrl;
    logic      stall;
    logic      taken;

    assign i_inst_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            fd_pc    <= '0;
            fd_instr <= '0; // decodes as nop
        end else begin
            pc <= npc;
            if (!stall) begin
                fd_pc    <= pc;
                fd_instr <= i_inst_rdata;
            end
        end
    end

    assign op = fd_instr[31:26];
    assign rs = fd_instr[25:21];
    assign rt = fd_instr[20:16];
    assign rd = fd_instr[15:11];
    assign fn = fd_instr[5:0];

    always_comb begin
        ctrl = '0;
        ctrl.tuse_rs = TUSE_NONE;
        ctrl.tuse_rt = TUSE_NONE;
        case (op)
            OP_SPECIAL: begin
                if (fd_instr != '0) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.dst = rd;
                    ctrl.tnew = TNEW_ALU;
                    ctrl.tuse_rs = TUSE_ALU;
                    ctrl.tuse_rt = TUSE_ALU;
                    case (fn)
                        FN_ADDU: ctrl.alu_op = ALU_ADD;
                        FN_SUBU: ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_OR:   ctrl.alu_op = ALU_OR;
                        FN_SLT:  ctrl.alu_op = ALU_SLT;
                        FN_SLL: begin
                            ctrl.alu_op = ALU_SLL;
                            ctrl.tuse_rs = TUSE_NONE;
                        end
                        default: begin
                            ctrl.reg_write = 1'b0;
                            ctrl.tnew = '0;
                            ctrl.tuse_rs = TUSE_NONE;
                            ctrl.tuse_rt = TUSE_NONE;
                        end
                    endcase
                end
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst = rt;
                ctrl.tnew = TNEW_ALU;
                ctrl.tuse_rs = TUSE_ALU;
                if (op == OP_ORI) begin
                    ctrl.alu_op = ALU_OR;
                    ctrl.zero_ext = 1'b1;
                end
                if (op == OP_LUI) begin
                    ctrl.alu_op = ALU_LUI;
                    ctrl.tuse_rs = TUSE_NONE;
                end
                if (op == OP_LW) begin
                    ctrl.wd_src = WD_MEM;
                    ctrl.tnew = TNEW_LOAD;
                end
            end
            OP_SW: begin
                ctrl.b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.tuse_rs = TUSE_ALU;
                ctrl.tuse_rt = TUSE_STORE; // data fixed up again in M
            end
            OP_BEQ: begin
                ctrl.tuse_rs = TUSE_BRANCH;
                ctrl.tuse_rt = TUSE_BRANCH;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.dst = LINK_REG;
                ctrl.wd_src = WD_LINK;
                ctrl.tnew = TNEW_ALU;
            end
            default: ;
        endcase
    end

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .rs_data (rf_rs),
        .rt_data (rf_rt),
        .w_fwd   (w_fwd)
    );

    hazard_unit u_hazard (
        .rs       (rs),
        .rt       (rt),
        .tuse_rs  (ctrl.tuse_rs),
        .tuse_rt  (ctrl.tuse_rt),
        .e_hazard (e_hazard),
        .m_hazard (m_hazard),
        .stall    (stall)
    );

    assign rs_val = fwd_pick(rs, rf_rs, m_fwd, w_fwd);
    assign rt_val = fwd_pick(rt, rf_rt, m_fwd, w_fwd);

    // branch resolved here, F already holds the delay slot
    assign pc_plus4_d = fd_pc + 32'd4;
    assign br_target  = pc_plus4_d + {{14{fd_instr[15]}}, fd_instr[15:0], 2'b00};
    assign jal_target = {pc_plus4_d[31:28], fd_instr[25:0], 2'b00};
    assign taken      = (op == OP_BEQ) && (rs_val == rt_val);

    always_comb begin
        if (stall)
            npc = pc;
        else if (taken)
            npc = br_target;
        else if (op == OP_JAL)
            npc = jal_target;
        else
            npc = pc + 32'd4;
    end

    assign de_out = stall ? '0 : '{pc: fd_pc, instr: fd_instr, rs_val: rs_val,
                                   rt_val: rt_val, ctrl: ctrl};

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  de_reg_t de_in,
    input  fwd_t    m_fwd,
    input  fwd_t    w_fwd,
    output em_reg_t em_out,
    output hazard_t e_hazard
);

    de_reg_t de_q;
    word_t   a;
    word_t   rt_val;
    word_t   imm;
    word_t   b;
    word_t   alu_res;
    ctrl_t   ctrl_e;
    logic [4:0] shamt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            de_q <= '0;
        else
            de_q <= de_in;
    end

    // operands may have been produced after D read them
    assign a      = fwd_pick(de_q.instr[25:21], de_q.rs_val, m_fwd, w_fwd);
    assign rt_val = fwd_pick(de_q.instr[20:16], de_q.rt_val, m_fwd, w_fwd);

    assign imm   = de_q.ctrl.zero_ext ? {16'b0, de_q.instr[15:0]}
                                      : {{16{de_q.instr[15]}}, de_q.instr[15:0]};
    assign b     = de_q.ctrl.b_imm ? imm : rt_val;
    assign shamt = de_q.instr[10:6];

    always_comb begin
        case (de_q.ctrl.alu_op)
            ALU_ADD: alu_res = a + b;
            ALU_SUB: alu_res = a - b;
            ALU_AND: alu_res = a & b;
            ALU_OR:  alu_res = a | b;
            ALU_SLT: alu_res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: alu_res = b << shamt;
            ALU_LUI: alu_res = {b[15:0], 16'b0};
            default: alu_res = '0;
        endcase
    end

    // tnew counts down one per stage
    always_comb begin
        ctrl_e = de_q.ctrl;
        ctrl_e.tnew = tnew_next(de_q.ctrl.tnew);
    end

    assign em_out = '{pc: de_q.pc, instr: de_q.instr, alu_res: alu_res,
                      rt_val: rt_val, ctrl: ctrl_e};

    assign e_hazard = '{reg_write: ctrl_e.reg_write, dst: ctrl_e.dst, tnew: ctrl_e.tnew};

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  tstage_t   tuse_rs,
    input  tstage_t   tuse_rt,
    input  hazard_t   e_hazard,
    input  hazard_t   m_hazard,
    output logic      stall
);

    // producer not ready by the time the consumer needs it
    function automatic logic late(reg_addr_t src, tstage_t tuse, hazard_t hz);
        return hz.reg_write && src != '0 && src == hz.dst && hz.tnew > tuse;
    endfunction

    logic rs_stall;
    logic rt_stall;

    assign rs_stall = late(rs, tuse_rs, e_hazard) || late(rs, tuse_rs, m_hazard);
    assign rt_stall = late(rt, tuse_rt, e_hazard) || late(rt, tuse_rt, m_hazard);
    assign stall    = rs_stall || rt_stall;

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/100ps

module mips_core
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    output word_t     i_inst_addr,
    input  word_t     i_inst_rdata,

    output word_t     m_data_addr,
    output word_t     m_data_wdata,
    output logic      m_data_we,
    input  word_t     m_data_rdata,

    output logic      w_grf_we,
    output reg_addr_t w_grf_addr,
    output word_t     w_grf_wdata,
    output word_t     w_inst_addr
);

    de_reg_t de;
    em_reg_t em;
    fwd_t    m_fwd;
    fwd_t    w_fwd;
    hazard_t e_hazard;
    hazard_t m_hazard;

    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_addr  (i_inst_addr),
        .i_inst_rdata (i_inst_rdata),
        .m_fwd        (m_fwd),
        .w_fwd        (w_fwd),
        .e_hazard     (e_hazard),
        .m_hazard     (m_hazard),
        .de_out       (de)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .de_in    (de),
        .m_fwd    (m_fwd),
        .w_fwd    (w_fwd),
        .em_out   (em),
        .e_hazard (e_hazard)
    );

    result_stage u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .em_in        (em),
        .m_data_addr  (m_data_addr),
        .m_data_wdata (m_data_wdata),
        .m_data_we    (m_data_we),
        .m_data_rdata (m_data_rdata),
        .m_fwd        (m_fwd),
        .w_fwd        (w_fwd),
        .m_hazard     (m_hazard),
        .w_grf_we     (w_grf_we),
        .w_grf_addr   (w_grf_addr),
        .w_grf_wdata  (w_grf_wdata),
        .w_inst_addr  (w_inst_addr)
    );

endmodule

//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // major opcodes, instr[31:26]
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // SPECIAL function codes, instr[5:0]
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    localparam word_t     RESET_PC = 32'h0000_3000;
    localparam reg_addr_t LINK_REG = 5'd31; // $ra

endpackage

//--- rtl/mips_pipe_pkg.sv
package mips_pipe_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WD_ALU,
        WD_MEM,
        WD_LINK // pc+8
    } wd_src_e;

    typedef logic [1:0] tstage_t;

    // cycles until an operand is needed, counted from D
    localparam tstage_t TUSE_BRANCH = 2'd0;
    localparam tstage_t TUSE_ALU    = 2'd1;
    localparam tstage_t TUSE_STORE  = 2'd2;
    localparam tstage_t TUSE_NONE   = 2'd3; // never compared as a real need

    // cycles until a result reaches a forwarding source, counted from D
    localparam tstage_t TNEW_ALU  = 2'd2;
    localparam tstage_t TNEW_LOAD = 2'd3;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      b_imm;     // alu b from immediate
        logic      zero_ext;
        logic      reg_write;
        logic      mem_write;
        wd_src_e   wd_src;
        reg_addr_t dst;
        tstage_t   tuse_rs;
        tstage_t   tuse_rt;
        tstage_t   tnew;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t rs_val;
        word_t rt_val;
        ctrl_t ctrl;
    } de_reg_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t alu_res;
        word_t rt_val;
        ctrl_t ctrl;
    } em_reg_t;

    typedef struct packed {
        word_t pc;
        word_t alu_res;
        word_t load_data;
        ctrl_t ctrl;
    } mw_reg_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dst;
        word_t     value;
    } fwd_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dst;
        tstage_t   tnew;
    } hazard_t;

    localparam fwd_t FWD_NONE = '0;

    // newest value wins, $0 is never forwarded
    function automatic word_t fwd_pick(reg_addr_t src, word_t reg_val, fwd_t m, fwd_t w);
        if (src != '0 && m.we && m.dst == src)
            return m.value;
        if (src != '0 && w.we && w.dst == src)
            return w.value;
        return reg_val;
    endfunction

    function automatic tstage_t tnew_next(tstage_t t);
        return (t == '0) ? '0 : t - 2'd1;
    endfunction

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_data,
    output word_t     rt_data,
    input  fwd_t      w_fwd
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (w_fwd.we && w_fwd.dst != '0) begin
            regs[w_fwd.dst] <= w_fwd.value;
        end
    end

    // write-through for a same-cycle read
    assign rs_data = (w_fwd.we && rs != '0 && w_fwd.dst == rs) ? w_fwd.value : regs[rs];
    assign rt_data = (w_fwd.we && rt != '0 && w_fwd.dst == rt) ? w_fwd.value : regs[rt];

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/100ps

module result_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  em_reg_t   em_in,
    output word_t     m_data_addr,
    output word_t     m_data_wdata,
    output logic      m_data_we,
    input  word_t     m_data_rdata,
    output fwd_t      m_fwd,
    output fwd_t      w_fwd,
    output hazard_t   m_hazard,
    output logic      w_grf_we,
    output reg_addr_t w_grf_addr,
    output word_t     w_grf_wdata,
    output word_t     w_inst_addr
);

    em_reg_t em_q;
    mw_reg_t mw_q;
    word_t   m_value;
    word_t   w_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em_q <= '0;
            mw_q <= '0;
        end else begin
            em_q <= em_in;
            mw_q <= '{pc: em_q.pc, alu_res: em_q.alu_res, load_data: m_data_rdata,
                      ctrl: em_q.ctrl};
        end
    end

    // M: data port, store data may come from a load now in W
    assign m_data_addr  = em_q.alu_res;
    assign m_data_wdata = fwd_pick(em_q.instr[20:16], em_q.rt_val, FWD_NONE, w_fwd);
    assign m_data_we    = em_q.ctrl.mem_write;

    assign m_value = (em_q.ctrl.wd_src == WD_LINK) ? em_q.pc + 32'd8 : em_q.alu_res;

    // load data is not ready in M
    assign m_fwd = '{we: em_q.ctrl.reg_write && em_q.ctrl.wd_src != WD_MEM,
                     dst: em_q.ctrl.dst, value: m_value};

    assign m_hazard = '{reg_write: em_q.ctrl.reg_write, dst: em_q.ctrl.dst,
                        tnew: tnew_next(em_q.ctrl.tnew)};

    always_comb begin
        case (mw_q.ctrl.wd_src)
            WD_MEM:  w_value = mw_q.load_data;
            WD_LINK: w_value = mw_q.pc + 32'd8;
            default: w_value = mw_q.alu_res;
        endcase
    end

    assign w_fwd = '{we: mw_q.ctrl.reg_write, dst: mw_q.ctrl.dst, value: w_value};

    // trace port, $0 writes show up here too
    assign w_grf_we    = mw_q.ctrl.reg_write;
    assign w_grf_addr  = mw_q.ctrl.dst;
    assign w_grf_wdata = w_value;
    assign w_inst_addr = mw_q.pc;

endmodule

//--- tb.f
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/mips_core.sv
tests/tb_mips.sv

//--- tests/tb_mips.sv
`timescale 1ns/100ps

module tb_mips
    import mips_isa_pkg::*;
();

    localparam int PROG_LEN    = 200;
    localparam int IMEM_WORDS  = 256;
    localparam int CYCLE_LIMIT = 4 * PROG_LEN + 100;
    localparam word_t END_PC   = RESET_PC + 32'(4 * (PROG_LEN - 2)); // self-loop beq

    typedef struct packed {
        word_t     pc;
        reg_addr_t dst;
        word_t     value;
    } trace_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic      clk;
    logic      rst_n;
    word_t     i_inst_addr;
    word_t     i_inst_rdata;
    word_t     m_data_addr;
    word_t     m_data_wdata;
    logic      m_data_we;
    word_t     m_data_rdata;
    logic      w_grf_we;
    reg_addr_t w_grf_addr;
    word_t     w_grf_wdata;
    word_t     w_inst_addr;

    word_t  imem [IMEM_WORDS];
    word_t  dmem [64];       // seen by the DUT
    word_t  model_dmem [64]; // private to the reference model
    word_t  model_regs [32];
    word_t  rng;
    int     cycles;
    trace_t exp_trace [$];
    store_t exp_store [$];

    mips_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_addr  (i_inst_addr),
        .i_inst_rdata (i_inst_rdata),
        .m_data_addr  (m_data_addr),
        .m_data_wdata (m_data_wdata),
        .m_data_we    (m_data_we),
        .m_data_rdata (m_data_rdata),
        .w_grf_we     (w_grf_we),
        .w_grf_addr   (w_grf_addr),
        .w_grf_wdata  (w_grf_wdata),
        .w_inst_addr  (w_inst_addr)
    );

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13); // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // small register set so that dependencies are frequent
    function automatic reg_addr_t pick_reg();
        word_t n;
        n = next_rand() % 32'd9;
        return (n == 32'd8) ? LINK_REG : n[4:0];
    endfunction

    function automatic word_t rtype_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                         logic [4:0] sh, funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h0001_0003) ^ 32'ha5c3_0000;
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off < 32'(IMEM_WORDS * 4))
            return imem[off[9:2]];
        else
            return '0;
    endfunction

    function automatic word_t load_word(word_t addr);
        if (addr[31:8] == '0)
            return dmem[addr[7:2]];
        else
            return '0;
    endfunction

    task automatic gen_program();
        word_t     kind;
        word_t     r;
        word_t     k;
        word_t     tgt;
        logic      in_slot;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        in_slot = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i[7:0]] = '0;
        for (int i = 0; i < PROG_LEN - 2; i++) begin
            kind = next_rand() % 32'd13;
            // no control in a delay slot or too close to the end
            if (kind >= 32'd11 && (in_slot || i > PROG_LEN - 8))
                kind = kind - 32'd11;
            in_slot = (kind >= 32'd11);
            rs = pick_reg();
            rt = pick_reg();
            rd = pick_reg();
            r = next_rand();
            k = 32'd2 + r % 32'd5; // forward distance in instructions
            case (kind)
                32'd0: imem[i[7:0]] = rtype_word(rs, rt, rd, 5'd0, FN_ADDU);
                32'd1: imem[i[7:0]] = rtype_word(rs, rt, rd, 5'd0, FN_SUBU);
                32'd2: imem[i[7:0]] = rtype_word(rs, rt, rd, 5'd0, FN_AND);
                32'd3: imem[i[7:0]] = rtype_word(rs, rt, rd, 5'd0, FN_OR);
                32'd4: imem[i[7:0]] = rtype_word(rs, rt, rd, 5'd0, FN_SLT);
                32'd5: imem[i[7:0]] = rtype_word(5'd0, rt, rd, r[4:0], FN_SLL);
                32'd6: imem[i[7:0]] = itype_word(OP_ADDIU, rs, rt, r[15:0]);
                32'd7: imem[i[7:0]] = itype_word(OP_ORI, rs, rt, r[15:0]);
                32'd8: imem[i[7:0]] = itype_word(OP_LUI, 5'd0, rt, r[15:0]);
                32'd9: imem[i[7:0]] = itype_word(OP_LW, 5'd0, rt, {8'b0, r[5:0], 2'b00});
                32'd10: imem[i[7:0]] = itype_word(OP_SW, 5'd0, rt, {8'b0, r[5:0], 2'b00});
                32'd11: imem[i[7:0]] = itype_word(OP_BEQ, rs, rt, k[15:0] - 16'd1);
                default: begin
                    tgt = RESET_PC + ((word_t'(i) + k) << 2);
                    imem[i[7:0]] = {OP_JAL, tgt[27:2]};
                end
            endcase
        end
        imem[8'(PROG_LEN - 2)] = itype_word(OP_BEQ, 5'd0, 5'd0, 16'hffff);
        imem[8'(PROG_LEN - 1)] = '0; // nop in its delay slot
    endtask

    task automatic init_data();
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] = fill_word({24'b0, i[5:0], 2'b00});
            model_dmem[i[5:0]] = dmem[i[5:0]];
        end
        for (int i = 0; i < 32; i++)
            model_regs[i[4:0]] = '0;
    endtask

    // in-order ISA model with delay slots
    task automatic run_model();
        word_t     pc;
        word_t     npc;
        word_t     pc4;
        word_t     next;
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     simm;
        word_t     val;
        word_t     addr;
        reg_addr_t dst;
        logic      wr;
        int        steps;
        pc = RESET_PC;
        npc = RESET_PC + 32'd4;
        steps = 0;
        while (pc != END_PC && steps < PROG_LEN) begin
            instr = fetch_word(pc);
            a = model_regs[instr[25:21]];
            b = model_regs[instr[20:16]];
            simm = {{16{instr[15]}}, instr[15:0]};
            pc4 = pc + 32'd4;
            next = npc + 32'd4;
            wr = 1'b1;
            dst = instr[20:16];
            val = '0;
            case (instr[31:26])
                OP_SPECIAL: begin
                    dst = instr[15:11];
                    case (instr[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_SLT:  val = {31'b0, $signed(a) < $signed(b)};
                        FN_SLL:  val = b << instr[10:6];
                        default: wr = 1'b0;
                    endcase
                    if (instr == '0)
                        wr = 1'b0; // nop
                end
                OP_ADDIU: val = a + simm;
                OP_ORI:   val = a | {16'b0, instr[15:0]};
                OP_LUI:   val = {instr[15:0], 16'b0};
                OP_LW: begin
                    addr = a + simm;
                    val = model_dmem[addr[7:2]];
                end
                OP_SW: begin
                    wr = 1'b0;
                    addr = a + simm;
                    exp_store.push_back('{addr: addr, data: b});
                    model_dmem[addr[7:2]] = b;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b)
                        next = pc4 + (simm << 2);
                end
                OP_JAL: begin
                    dst = LINK_REG;
                    val = pc + 32'd8;
                    next = {pc4[31:28], instr[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                exp_trace.push_back('{pc: pc, dst: dst, value: val});
                if (dst != '0)
                    model_regs[dst] = val; // $0 stays zero
            end
            pc = npc;
            npc = next;
            steps++;
        end
    endtask

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %08h, expected %08h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic sample_outputs();
        trace_t t;
        store_t s;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Test FAILED");
            $fatal(1, "timeout after %0d cycles, the core stopped retiring instructions",
                   cycles);
        end else begin
            if (w_grf_we) begin
                if (exp_trace.size() == 0) begin
                    $display("Test FAILED");
                    $fatal(1, "register write from pc %08h that the program never makes",
                           w_inst_addr);
                end else begin
                    t = exp_trace.pop_front();
                    check_equal(w_inst_addr, t.pc, "trace pc");
                    check_equal({27'b0, w_grf_addr}, {27'b0, t.dst}, "trace register");
                    check_equal(w_grf_wdata, t.value, "trace value");
                end
            end
            if (m_data_we) begin
                if (exp_store.size() == 0) begin
                    $display("Test FAILED");
                    $fatal(1, "store to %08h that the program never makes", m_data_addr);
                end else begin
                    s = exp_store.pop_front();
                    check_equal(m_data_addr, s.addr, "store address");
                    check_equal(m_data_wdata, s.data, "store data");
                    dmem[m_data_addr[7:2]] = m_data_wdata; // taken at the next edge
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory read data, 1 ns after the rising edge
    initial begin
        i_inst_rdata = '0;
        m_data_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            i_inst_rdata = fetch_word(i_inst_addr);
            m_data_rdata = load_word(m_data_addr);
        end
    end

    initial begin
        rst_n = 1'b0;
        rng = 32'd63;
        cycles = 0;
        gen_program();
        init_data();
        run_model();
        repeat (7) begin
            @(negedge clk);
            check_equal({31'b0, w_grf_we}, 32'd0, "w_grf_we in reset");
            check_equal({31'b0, m_data_we}, 32'd0, "m_data_we in reset");
            check_equal(i_inst_addr, RESET_PC, "fetch address in reset");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1; // after the 8th edge
        check_equal(i_inst_addr, RESET_PC, "first fetch address");
        while (exp_trace.size() != 0 || exp_store.size() != 0) begin
            @(negedge clk);
            sample_outputs();
        end
        repeat (10) begin
            @(negedge clk);
            sample_outputs(); // nothing more may retire
        end
        $display("Test OK");
        $finish;
    end

endmodule
